// ==== avg3_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module avg3_alu
(
    avg3_ctrl_if.alu alu,
    input wire avg3_pkg::data_t op_a,
    input wire avg3_pkg::data_t op_b,
    output avg3_pkg::data_t alu_result,
    output logic co,
    output logic z
);

    logic [$bits(avg3_pkg::data_t):0] sum; // one extra bit holds the carry

    assign sum = {1'b0, op_a} + {1'b0, op_b};

    always_comb
    begin
        case (alu.alu_op)
            avg3_pkg::alu_add:
            begin
                alu_result = sum[$bits(avg3_pkg::data_t)-1:0];
                co = sum[$bits(avg3_pkg::data_t)]; // set when the sum passed 255
            end
            default:
            begin
                alu_result = op_a & op_b; // mask test, never carries
                co = 1'b0;
            end
        endcase
    end

    assign z = ~|alu_result; // the sequencer branches on this for both functions

    // an add that carries wraps the 8-bit sum below op_a
    always_comb
    begin
        assert (co == (alu.alu_op == avg3_pkg::alu_add && alu_result < op_a))
        else $error("carry flag %0d disagrees with result %0d of operand %0d",
                    co, alu_result, op_a);
    end

endmodule

`default_nettype wire

// ==== avg3_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface avg3_ctrl_if;

    logic we; // register file write strobe
    avg3_pkg::reg_addr_t wr_addr; // destination slot
    avg3_pkg::reg_addr_t rd_addr; // slot copied when in_sel is in_sel_reg
    avg3_pkg::in_sel_e in_sel; // write source
    avg3_pkg::data_t const_val; // constant source
    avg3_pkg::alu_op_e alu_op; // function of the alu

    // the sequencer owns every control line
    modport seq
    (
        output we, wr_addr, rd_addr, in_sel, const_val, alu_op
    );

    modport rf
    (
        input we, wr_addr, rd_addr, in_sel, const_val
    );

    modport alu
    (
        input alu_op
    );

endinterface

`default_nettype wire

// ==== avg3_pkg.sv ====
`default_nettype none
`include "avg3_settings.svh"

package avg3_pkg;

    typedef logic [`AVG3_DATA_W-1:0] data_t; // one operand or register word
    typedef logic [`AVG3_ADDR_W-1:0] reg_addr_t; // selects one of the sixteen slots

    typedef enum logic
    {
        alu_and = 1'b0, // bitwise and, used for the mask tests
        alu_add = 1'b1 // add with carry out
    } alu_op_e;

    // source of the value written into the register file
    typedef enum logic [2:0]
    {
        in_sel_port_a,
        in_sel_port_b,
        in_sel_const, // constant supplied by the sequencer
        in_sel_alu,
        in_sel_reg // copy of the slot named by rd_addr
    } in_sel_e;

    typedef enum logic [5:0]
    {
        st_idle, st_get_a, st_get_b, st_wait_c, st_get_c, // operand load
        st_clr_quot, st_sum_ab, st_load_c0, st_load_c1, st_sum_c0, st_sum_c1,
        st_carry0, st_carry1, st_carry2, // carry count into slot 15
        st_ld_m3, st_ld_sum, st_sub, st_inc_ld, st_inc_one, st_inc_st, // divide loop
        st_fin_ld, st_fin_one, st_fin_st, // last increment when the sum hits three
        st_and1, st_mod_test, st_mod0, st_mod1, st_mod2, // remainder into slot 5
        st_chk_cry, st_ld_cry, st_test_any, st_mask2, st_test_two,
        st_one_carry, st_one_test, st_two_carry, st_two_mask, st_two_test,
        st_set85, st_set86, st_set170, st_set171, // correction constant into slot 2
        st_add_ld, st_add_st, st_finish, st_done
    } seq_state_e;

endpackage

`default_nettype wire

// ==== avg3_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "avg3_settings.svh"

module avg3_regfile
(
    input wire logic clk,
    input wire logic reset,
    avg3_ctrl_if.rf ctrl,
    input wire avg3_pkg::data_t in_a,
    input wire avg3_pkg::data_t in_b,
    input wire avg3_pkg::data_t alu_result,
    output avg3_pkg::data_t op_a,
    output avg3_pkg::data_t op_b,
    output avg3_pkg::data_t result
);

    avg3_pkg::data_t regs [`AVG3_REG_COUNT]; // slot roles are fixed by the sequencer
    avg3_pkg::data_t wr_data; // value that lands at the next write edge

    always_comb
    begin
        case (ctrl.in_sel)
            avg3_pkg::in_sel_port_a: wr_data = in_a; // also carries C in the load phase
            avg3_pkg::in_sel_port_b: wr_data = in_b;
            avg3_pkg::in_sel_const: wr_data = ctrl.const_val;
            avg3_pkg::in_sel_alu: wr_data = alu_result;
            avg3_pkg::in_sel_reg: wr_data = regs[ctrl.rd_addr]; // slot to slot copy
            default: wr_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `AVG3_REG_COUNT; i++)
                regs[i] <= '0; // result reads 0 until the first run ends
        end
        else if (ctrl.we)
        begin
            regs[ctrl.wr_addr] <= wr_data;
        end
    end

    assign op_a = regs[`AVG3_REG_OPA]; // the alu always sees slots 1 and 2
    assign op_b = regs[`AVG3_REG_OPB];
    assign result = regs[`AVG3_REG_OUT];

    // a copy onto its own slot would leave the destination unchanged
    a_copy_distinct: assert property (@(posedge clk) disable iff (reset)
        (ctrl.we && ctrl.in_sel == avg3_pkg::in_sel_reg) |-> ctrl.rd_addr != ctrl.wr_addr)
        else $error("copy of slot %0d onto itself", ctrl.wr_addr);

endmodule

`default_nettype wire

// ==== avg3_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "avg3_settings.svh"

module avg3_sequencer
(
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic co,
    input wire logic z,
    avg3_ctrl_if.seq ctrl,
    output logic busy
);

    avg3_pkg::seq_state_e state;
    avg3_pkg::seq_state_e next_state;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= avg3_pkg::st_idle;
        else
            state <= next_state;
    end

    // co and z always describe the slots 1 and 2 of the current cycle
    always_comb
    begin
        case (state)
            avg3_pkg::st_idle: next_state = start ? avg3_pkg::st_get_a : avg3_pkg::st_idle;
            avg3_pkg::st_get_a: next_state = avg3_pkg::st_get_b;
            avg3_pkg::st_get_b: next_state = avg3_pkg::st_wait_c; // environment swaps to C
            avg3_pkg::st_wait_c: next_state = avg3_pkg::st_get_c;
            avg3_pkg::st_get_c: next_state = avg3_pkg::st_clr_quot;
            avg3_pkg::st_clr_quot: next_state = avg3_pkg::st_sum_ab;
            avg3_pkg::st_sum_ab: next_state = co ? avg3_pkg::st_load_c1 : avg3_pkg::st_load_c0;
            avg3_pkg::st_load_c0: next_state = avg3_pkg::st_sum_c0;
            avg3_pkg::st_load_c1: next_state = avg3_pkg::st_sum_c1;
            avg3_pkg::st_sum_c0: next_state = co ? avg3_pkg::st_carry1 : avg3_pkg::st_carry0;
            avg3_pkg::st_sum_c1: next_state = co ? avg3_pkg::st_carry2 : avg3_pkg::st_carry1;
            avg3_pkg::st_carry0, avg3_pkg::st_carry1, avg3_pkg::st_carry2:
                next_state = z ? avg3_pkg::st_mod0 : avg3_pkg::st_ld_m3; // zero low byte
            avg3_pkg::st_ld_m3: next_state = avg3_pkg::st_ld_sum;
            avg3_pkg::st_ld_sum: next_state = avg3_pkg::st_sub;
            avg3_pkg::st_sub:
            begin
                if (z)
                    next_state = avg3_pkg::st_fin_ld; // exactly three was left
                else if (co)
                    next_state = avg3_pkg::st_inc_ld; // more than three, keep dividing
                else
                    next_state = avg3_pkg::st_and1; // one or two left over
            end
            avg3_pkg::st_inc_ld: next_state = avg3_pkg::st_inc_one;
            avg3_pkg::st_inc_one: next_state = avg3_pkg::st_inc_st;
            avg3_pkg::st_inc_st: next_state = avg3_pkg::st_ld_m3;
            avg3_pkg::st_fin_ld: next_state = avg3_pkg::st_fin_one;
            avg3_pkg::st_fin_one: next_state = avg3_pkg::st_fin_st;
            avg3_pkg::st_fin_st: next_state = avg3_pkg::st_mod0;
            avg3_pkg::st_and1: next_state = avg3_pkg::st_mod_test;
            avg3_pkg::st_mod_test: next_state = z ? avg3_pkg::st_mod2 : avg3_pkg::st_mod1;
            avg3_pkg::st_mod0, avg3_pkg::st_mod1, avg3_pkg::st_mod2:
                next_state = avg3_pkg::st_chk_cry;
            avg3_pkg::st_chk_cry: next_state = avg3_pkg::st_ld_cry;
            avg3_pkg::st_ld_cry: next_state = avg3_pkg::st_test_any;
            avg3_pkg::st_test_any: next_state = z ? avg3_pkg::st_finish : avg3_pkg::st_mask2;
            avg3_pkg::st_mask2: next_state = avg3_pkg::st_test_two;
            avg3_pkg::st_test_two:
                next_state = z ? avg3_pkg::st_one_carry : avg3_pkg::st_two_carry;
            avg3_pkg::st_one_carry: next_state = avg3_pkg::st_one_test;
            avg3_pkg::st_one_test: next_state = z ? avg3_pkg::st_set85 : avg3_pkg::st_set86;
            avg3_pkg::st_two_carry: next_state = avg3_pkg::st_two_mask;
            avg3_pkg::st_two_mask: next_state = avg3_pkg::st_two_test;
            avg3_pkg::st_two_test: next_state = z ? avg3_pkg::st_set170 : avg3_pkg::st_set171;
            avg3_pkg::st_set85, avg3_pkg::st_set86, avg3_pkg::st_set170, avg3_pkg::st_set171:
                next_state = avg3_pkg::st_add_ld;
            avg3_pkg::st_add_ld: next_state = avg3_pkg::st_add_st;
            avg3_pkg::st_add_st: next_state = avg3_pkg::st_finish;
            avg3_pkg::st_finish: next_state = avg3_pkg::st_done;
            default: next_state = avg3_pkg::st_idle; // st_done and unused codes
        endcase
    end

    // Moore outputs, one small decode per control line
    always_comb
    begin
        case (state)
            avg3_pkg::st_idle, avg3_pkg::st_wait_c, avg3_pkg::st_mod_test,
            avg3_pkg::st_test_any, avg3_pkg::st_test_two, avg3_pkg::st_one_test,
            avg3_pkg::st_two_test, avg3_pkg::st_done: ctrl.we = 1'b0; // flag test cycles
            default: ctrl.we = 1'b1;
        endcase

        case (state)
            avg3_pkg::st_get_b, avg3_pkg::st_load_c0, avg3_pkg::st_load_c1,
            avg3_pkg::st_ld_m3, avg3_pkg::st_inc_one, avg3_pkg::st_fin_one,
            avg3_pkg::st_and1, avg3_pkg::st_chk_cry, avg3_pkg::st_mask2,
            avg3_pkg::st_two_mask, avg3_pkg::st_set85, avg3_pkg::st_set86,
            avg3_pkg::st_set170, avg3_pkg::st_set171: ctrl.wr_addr = `AVG3_REG_OPB;
            avg3_pkg::st_get_c: ctrl.wr_addr = `AVG3_REG_C;
            avg3_pkg::st_sum_c0, avg3_pkg::st_sum_c1, avg3_pkg::st_sub:
                ctrl.wr_addr = 4'(`AVG3_REG_SUM);
            avg3_pkg::st_clr_quot, avg3_pkg::st_inc_st, avg3_pkg::st_fin_st,
            avg3_pkg::st_add_st: ctrl.wr_addr = `AVG3_REG_QUOT;
            avg3_pkg::st_carry0, avg3_pkg::st_carry1, avg3_pkg::st_carry2:
                ctrl.wr_addr = `AVG3_REG_CARRY;
            avg3_pkg::st_mod0, avg3_pkg::st_mod1, avg3_pkg::st_mod2: ctrl.wr_addr = `AVG3_REG_MOD;
            avg3_pkg::st_finish: ctrl.wr_addr = `AVG3_REG_OUT;
            default: ctrl.wr_addr = `AVG3_REG_OPA; // also the idle value, we is low there
        endcase

        case (state)
            avg3_pkg::st_load_c0, avg3_pkg::st_load_c1: ctrl.rd_addr = `AVG3_REG_C;
            avg3_pkg::st_ld_sum: ctrl.rd_addr = 4'(`AVG3_REG_SUM);
            avg3_pkg::st_ld_cry: ctrl.rd_addr = `AVG3_REG_CARRY;
            avg3_pkg::st_one_carry, avg3_pkg::st_two_carry: ctrl.rd_addr = `AVG3_REG_MOD;
            default: ctrl.rd_addr = `AVG3_REG_QUOT; // quotient reloads and final copy
        endcase

        case (state)
            avg3_pkg::st_get_a, avg3_pkg::st_get_c: ctrl.in_sel = avg3_pkg::in_sel_port_a;
            avg3_pkg::st_get_b: ctrl.in_sel = avg3_pkg::in_sel_port_b;
            avg3_pkg::st_load_c0, avg3_pkg::st_load_c1, avg3_pkg::st_ld_sum,
            avg3_pkg::st_inc_ld, avg3_pkg::st_fin_ld, avg3_pkg::st_ld_cry,
            avg3_pkg::st_one_carry, avg3_pkg::st_two_carry, avg3_pkg::st_add_ld,
            avg3_pkg::st_finish: ctrl.in_sel = avg3_pkg::in_sel_reg;
            avg3_pkg::st_sum_ab, avg3_pkg::st_sum_c0, avg3_pkg::st_sum_c1,
            avg3_pkg::st_sub, avg3_pkg::st_inc_st, avg3_pkg::st_fin_st,
            avg3_pkg::st_mod1, avg3_pkg::st_add_st: ctrl.in_sel = avg3_pkg::in_sel_alu;
            default: ctrl.in_sel = avg3_pkg::in_sel_const;
        endcase

        case (state)
            avg3_pkg::st_carry1, avg3_pkg::st_inc_one, avg3_pkg::st_fin_one,
            avg3_pkg::st_and1: ctrl.const_val = 8'd1;
            avg3_pkg::st_carry2, avg3_pkg::st_mod2, avg3_pkg::st_mask2: ctrl.const_val = 8'd2;
            avg3_pkg::st_chk_cry, avg3_pkg::st_two_mask: ctrl.const_val = 8'd3; // low two bits
            avg3_pkg::st_ld_m3: ctrl.const_val = `AVG3_CONST_M3;
            avg3_pkg::st_set85: ctrl.const_val = `AVG3_ONE_CARRY_LO; // 256 is 3*85 plus 1
            avg3_pkg::st_set86: ctrl.const_val = `AVG3_ONE_CARRY_HI;
            avg3_pkg::st_set170: ctrl.const_val = `AVG3_TWO_CARRY_LO; // 512 is 3*170 plus 2
            avg3_pkg::st_set171: ctrl.const_val = `AVG3_TWO_CARRY_HI;
            default: ctrl.const_val = 8'd0;
        endcase

        case (state)
            avg3_pkg::st_mod_test, avg3_pkg::st_mod1, avg3_pkg::st_test_any,
            avg3_pkg::st_test_two, avg3_pkg::st_one_test,
            avg3_pkg::st_two_test: ctrl.alu_op = avg3_pkg::alu_and;
            default: ctrl.alu_op = avg3_pkg::alu_add;
        endcase
    end

    assign busy = (state != avg3_pkg::st_idle);

    // the result slot is written once per run, from the state two edges before busy drops
    a_out_write: assert property (@(posedge clk) disable iff (reset)
        (ctrl.we && ctrl.wr_addr == `AVG3_REG_OUT) |-> state == avg3_pkg::st_finish ##2 !busy)
        else $error("result slot written outside the final copy");

    // a zero after adding minus three means three was left, which always carries
    a_sub_flags: assert property (@(posedge clk) disable iff (reset)
        (state == avg3_pkg::st_sub && z) |-> co)
        else $error("divide step gave a zero sum without a carry");

endmodule

`default_nettype wire

// ==== avg3_settings.svh ====
`ifndef AVG3_SETTINGS_SVH
`define AVG3_SETTINGS_SVH

// datapath width and register file geometry
`define AVG3_DATA_W 8
`define AVG3_REG_COUNT 16
`define AVG3_ADDR_W 4

// fixed roles of the register file slots
`define AVG3_REG_OUT 4'd0
`define AVG3_REG_OPA 4'd1
`define AVG3_REG_OPB 4'd2
`define AVG3_REG_C 4'd3
`define AVG3_REG_MOD 4'd5
`define AVG3_REG_SUM 9
`define AVG3_REG_QUOT 4'd10
`define AVG3_REG_CARRY 4'd15

// minus three in two's complement and the carry corrections
`define AVG3_CONST_M3 8'hFD
`define AVG3_ONE_CARRY_LO 8'd85
`define AVG3_ONE_CARRY_HI 8'd86
`define AVG3_TWO_CARRY_LO 8'd170
`define AVG3_TWO_CARRY_HI 8'd171

`endif

// ==== avg3_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module avg3_top
(
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire avg3_pkg::data_t in_a, // A, then C two cycles later
    input wire avg3_pkg::data_t in_b,
    output wire logic busy,
    output wire avg3_pkg::data_t result
);

    wire avg3_pkg::data_t op_a; // slot 1
    wire avg3_pkg::data_t op_b; // slot 2
    wire avg3_pkg::data_t alu_result;
    wire logic co;
    wire logic z;

    avg3_ctrl_if ctrl_if ();

    avg3_sequencer avg3_sequencer_inst
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .co(co),
        .z(z),
        .ctrl(ctrl_if.seq),
        .busy(busy)
    );

    avg3_regfile avg3_regfile_inst
    (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl_if.rf),
        .in_a(in_a),
        .in_b(in_b),
        .alu_result(alu_result),
        .op_a(op_a),
        .op_b(op_b),
        .result(result)
    );

    avg3_alu avg3_alu_inst
    (
        .alu(ctrl_if.alu),
        .op_a(op_a),
        .op_b(op_b),
        .alu_result(alu_result),
        .co(co),
        .z(z)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compiles the avg3 testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_avg3 \
    -f vlog.f -o sim_avg3; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_avg3)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run counts as good only when the testbench printed its pass line
if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// ==== tb_avg3.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_avg3;

    localparam int run_count = 208; // seven directed, two hundred random, one stray start
    localparam int max_run_cycles = 600; // longest run is about 560 cycles
    localparam int timeout_cycles = run_count * max_run_cycles + 25200;

    logic clk;
    logic reset;
    logic start;
    avg3_pkg::data_t in_a;
    avg3_pkg::data_t in_b;
    logic busy;
    avg3_pkg::data_t result;

    avg3_pkg::data_t expected; // model value of the run in flight
    string test_name; // shown in error lines, one per run
    string group_name; // shown in the per-test summary line
    logic started; // stays low until the first start is driven
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start = 0;
    int cycle_count = 0;
    logic [31:0] rng_state;

    avg3_top avg3_top_inst
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .in_a(in_a),
        .in_b(in_b),
        .busy(busy),
        .result(result)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // nothing may move before the first start, reset included
    a_reset_busy: assert property (@(posedge clk) !started |-> !busy)
        else
        begin
            error_count++;
            $display("busy was high before the first start");
        end

    a_reset_result: assert property (@(posedge clk) !started |-> result == 8'd0)
        else
        begin
            error_count++;
            $display("error reset_state: expected 0, actual %0d", $sampled(result));
        end

    // E0 is the edge with start high and busy low, busy follows one edge later
    a_busy_rise: assert property (@(posedge clk) disable iff (reset)
        start && !busy |=> busy)
        else
        begin
            error_count++;
            $display("busy did not rise one cycle after start in %s", test_name);
        end

    // also catches a second run launched by a start that came while busy
    a_no_stray_run: assert property (@(posedge clk) disable iff (reset)
        !start && !busy |=> !busy)
        else
        begin
            error_count++;
            $display("busy rose without a start in %s", test_name);
        end

    a_result: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> result == expected)
        else
        begin
            error_count++;
            $display("error %s: expected %0d, actual %0d", test_name,
                     $sampled(expected), $sampled(result));
        end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // floor of the mean on full width integers, no carry tricks
    function automatic avg3_pkg::data_t model_avg(input avg3_pkg::data_t a,
                                                  input avg3_pkg::data_t b,
                                                  input avg3_pkg::data_t c);
        int total;
        total = int'(a) + int'(b) + int'(c);
        return 8'(total / 3);
    endfunction

    task automatic start_test(input string name);
        group_name = name;
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count != errors_at_start)
        begin
            tests_failed++;
            $display("test %s failed", group_name);
        end
        else
            $display("test %s passed", group_name);
    endtask

    // entered 1 ns after an edge with busy low, leaves 1 ns after E4
    task automatic begin_run(input avg3_pkg::data_t a, input avg3_pkg::data_t b,
                             input avg3_pkg::data_t c);
        expected = model_avg(a, b, c);
        started = 1'b1;
        start = 1'b1;
        in_a = a;
        in_b = b;
        @(posedge clk); // E0
        #1 start = 1'b0;
        @(posedge clk); // A lands in slot 1
        @(posedge clk); // B lands in slot 2
        #1 in_a = c;
        @(posedge clk);
        @(posedge clk); // C lands in slot 3
        #1;
    endtask

    task automatic wait_idle();
        while (busy)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk); // a_result sees the fall of busy at this edge
        #1;
    endtask

    task automatic run_triple(input string name, input avg3_pkg::data_t a,
                              input avg3_pkg::data_t b, input avg3_pkg::data_t c);
        start_test(name);
        begin_run(a, b, c);
        wait_idle();
        end_test();
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        in_a = 8'd0;
        in_b = 8'd0;
        started = 1'b0;
        expected = 8'd0;
        rng_state = 32'hb8dd_e758;
        start_test("reset_state");
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        repeat (4) @(posedge clk); // idle cycles after reset, result must stay 0
        #1;
        end_test();

        run_triple("zero_sum", 8'd0, 8'd0, 8'd0); // skips the divide loop
        run_triple("rem0_loop", 8'd1, 8'd1, 8'd1); // sum hits exactly three
        run_triple("rem2_no_carry", 8'd2, 8'd0, 8'd0);
        run_triple("rem1_no_carry", 8'd1, 8'd0, 8'd0);
        run_triple("one_carry", 8'd200, 8'd100, 8'd10);
        run_triple("two_carry_max", 8'd255, 8'd255, 8'd255);
        run_triple("two_carry", 8'd255, 8'd255, 8'd1);

        start_test("random");
        for (int i = 0; i < 200; i++)
        begin
            rng_state = next_random(rng_state);
            test_name = $sformatf("random_%0d", i);
            begin_run(rng_state[7:0], rng_state[15:8], rng_state[23:16]);
            wait_idle();
        end
        end_test();

        start_test("start_while_busy");
        begin_run(8'd100, 8'd50, 8'd25);
        repeat (20) @(posedge clk); // well inside the divide loop
        #1;
        start = 1'b1;
        in_a = 8'd7; // different operands that must be ignored
        in_b = 8'd9;
        @(posedge clk);
        #1;
        start = 1'b0;
        in_a = 8'd0;
        in_b = 8'd0;
        wait_idle();
        repeat (8) @(posedge clk); // a second run would show up here
        #1;
        end_test();

        $display("tests %0d, failed tests %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
avg3_pkg.sv
avg3_ctrl_if.sv
avg3_alu.sv
avg3_regfile.sv
avg3_sequencer.sv
avg3_top.sv
tb_avg3.sv
